//--- channel/isi_channel.sv
`timescale 1ns/1ps
`include "serdes_macros.svh"

module isi_channel (
    input  logic                   clock,
    input  logic                   reset_n,
    input  serdes_pkg::tap_write_s tap_write,
    input  serdes_pkg::sample_s    sample_in,
    output serdes_pkg::sample_s    sample_out
);

    localparam int RES = `SERDES_SIGNAL_RESOLUTION;
    localparam int ACC_W = 2 * RES + 1;     // two products plus carry

    localparam logic signed [ACC_W-1:0] SAT_MAX = (2 ** (RES - 1)) - 1;
    localparam logic signed [ACC_W-1:0] SAT_MIN = -(2 ** (RES - 1));

    serdes_pkg::coef_t  taps [`SERDES_PULSE_LENGTH];    // [0] cursor, [1] post-cursor
    serdes_pkg::level_t prev_level;                     // last valid input

    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] scaled;
    serdes_pkg::level_t      clipped;

    always_comb begin
        // signed operands extend to ACC_W before the multiply
        acc    = sample_in.level * taps[0] + prev_level * taps[1];
        scaled = acc >>> `SERDES_COEF_SHIFT;    // drop fraction bits
        if (scaled > SAT_MAX)
            clipped = SAT_MAX[RES-1:0];
        else if (scaled < SAT_MIN)
            clipped = SAT_MIN[RES-1:0];
        else
            clipped = scaled[RES-1:0];
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < `SERDES_PULSE_LENGTH; i++)
                taps[i] <= '0;
            prev_level       <= '0;     // channel starts quiet
            sample_out.valid <= 1'b0;
        end else begin
            if (tap_write.write)
                taps[tap_write.index] <= tap_write.coef;
            if (sample_in.valid)
                prev_level <= sample_in.level;  // history only moves on real symbols
            sample_out.valid <= sample_in.valid;
        end
        sample_out.level <= clipped;
    end

    // unity cursor with no post-cursor passes each sample straight through
    a_unity_passthrough: assert property (@(posedge clock) disable iff (!reset_n)
        sample_in.valid && taps[0] == (1 << `SERDES_COEF_SHIFT) && taps[1] == '0
        |=> sample_out.level == $past(sample_in.level))
        else $error("unity channel altered a sample");

endmodule

//--- checker/prbs31_checker.sv
`timescale 1ns/1ps
`include "serdes_macros.svh"

module prbs31_checker (
    input  logic                           clock,
    input  logic                           reset_n,
    input  serdes_pkg::bits_s              bits_in,
    output logic [`SERDES_COUNT_WIDTH-1:0] bit_count,
    output logic [`SERDES_COUNT_WIDTH-1:0] error_count
);

    logic [30:0]       sr;          // local copy of the tx lfsr
    serdes_pkg::pair_t expected;
    serdes_pkg::pair_t diff;
    logic [1:0]        pair_errors; // 0, 1 or 2

    assign expected    = {sr[30] ^ sr[27], sr[29] ^ sr[26]};   // next two bits
    assign diff        = bits_in.pair ^ expected;
    assign pair_errors = {1'b0, diff[1]} + {1'b0, diff[0]};

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            sr          <= `SERDES_PRBS_SEED;
            bit_count   <= '0;
            error_count <= '0;
        end else if (bits_in.valid) begin
            // free-running reference, no resync on errors
            sr          <= {sr[28:0], expected};
            bit_count   <= bit_count + `SERDES_COUNT_WIDTH'(2);
            error_count <= error_count + `SERDES_COUNT_WIDTH'(pair_errors);
        end
    end

    a_errors_bounded: assert property (@(posedge clock) disable iff (!reset_n)
        error_count <= bit_count)
        else $error("error_count above bit_count");

endmodule

//--- common/serdes_macros.svh
`ifndef SERDES_MACROS_SVH
`define SERDES_MACROS_SVH

// voltage sample width, signed
`define SERDES_SIGNAL_RESOLUTION 8

// gap between adjacent pam-4 levels, gives -84/-28/+28/+84
`define SERDES_SYMBOL_SEPARATION 56

`define SERDES_PULSE_LENGTH 2       // channel taps, cursor + one post-cursor
`define SERDES_COEF_SHIFT   6       // tap fraction bits, 64 is unity gain

// shared by generator and checker so both start in step
`define SERDES_PRBS_SEED 31'b1101000101011010010010100011111

`define SERDES_COUNT_WIDTH 32       // bit and error counters

`endif

//--- common/serdes_pkg.sv
`include "serdes_macros.svh"

package serdes_pkg;

    typedef logic [1:0] pair_t;     // msb is the earlier prbs bit

    typedef logic signed [`SERDES_SIGNAL_RESOLUTION-1:0] level_t;
    typedef logic signed [`SERDES_SIGNAL_RESOLUTION-1:0] coef_t;   // q1.6 style, 64 = 1.0

    // two data bits per symbol
    typedef struct packed {
        pair_t pair;
        logic  valid;
    } bits_s;

    // one voltage sample on the line
    typedef struct packed {
        level_t level;
        logic   valid;
    } sample_s;

    // tap load word from outside, taken in order
    typedef struct packed {
        logic  valid;
        coef_t coef;
    } coef_load_s;

    // indexed tap write into the channel
    typedef struct packed {
        logic                                   write;
        logic [$clog2(`SERDES_PULSE_LENGTH)-1:0] index;
        coef_t                                  coef;
    } tap_write_s;

    typedef enum logic [1:0] {
        LINK_IDLE = 2'd0,   // waiting for load_start
        LINK_LOAD = 2'd1,   // taking tap words
        LINK_RUN  = 2'd2    // pattern flowing
    } link_state_e;

endpackage

//--- logic/link_control.sv
`timescale 1ns/1ps
`include "serdes_macros.svh"

module link_control (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   load_start,
    input  serdes_pkg::coef_load_s coef_load,
    input  logic                   prbs_en,
    output serdes_pkg::tap_write_s tap_write,
    output logic                   run_enable,
    output logic                   load_done
);

    serdes_pkg::link_state_e state;
    logic [$clog2(`SERDES_PULSE_LENGTH)-1:0] tap_idx;   // next tap to write

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state           <= serdes_pkg::LINK_IDLE;
            tap_idx         <= '0;
            tap_write.write <= 1'b0;
        end else begin
            tap_write.write <= 1'b0;                   // single-cycle strobe
            case (state)
                serdes_pkg::LINK_IDLE: begin
                    if (load_start)
                        state <= serdes_pkg::LINK_LOAD;
                end
                serdes_pkg::LINK_LOAD: begin
                    if (coef_load.valid) begin
                        tap_write.write <= 1'b1;
                        tap_idx         <= tap_idx + 1'b1;
                        // last tap taken, open the gate
                        if (tap_idx == `SERDES_PULSE_LENGTH - 1)
                            state <= serdes_pkg::LINK_RUN;
                    end
                end
                serdes_pkg::LINK_RUN: state <= serdes_pkg::LINK_RUN;   // sticky until reset
                default: state <= serdes_pkg::LINK_IDLE;
            endcase
        end
        // payload rides along with the strobe
        tap_write.index <= tap_idx;
        tap_write.coef  <= coef_load.coef;
    end

    assign load_done  = (state == serdes_pkg::LINK_RUN);
    assign run_enable = load_done && prbs_en;   // pattern only after taps are in

    // gate opens on the edge that sends the last tap out
    a_gate_after_last_tap: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(load_done) |-> tap_write.write
                             && tap_write.index == `SERDES_PULSE_LENGTH - 1)
        else $error("pattern gate opened before the last tap write");

endmodule

//--- logic/prbs31_gen.sv
`timescale 1ns/1ps
`include "serdes_macros.svh"

module prbs31_gen (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              run_enable,
    output serdes_pkg::bits_s bits_out
);

    logic [30:0] sr;            // fibonacci lfsr, x^31 + x^28 + 1
    logic        bit_first;     // first step feedback
    logic        bit_second;    // second step feedback

    // two steps unrolled, second uses the shifted register
    assign bit_first  = sr[30] ^ sr[27];
    assign bit_second = sr[29] ^ sr[26];

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            sr             <= `SERDES_PRBS_SEED;
            bits_out.valid <= 1'b0;
        end else begin
            bits_out.valid <= run_enable;
            if (run_enable)
                sr <= {sr[28:0], bit_first, bit_second};   // shift in both new bits
        end
        bits_out.pair <= {bit_first, bit_second};          // msb first
    end

endmodule

//--- logic/serdes_link.sv
`timescale 1ns/1ps
`include "serdes_macros.svh"

module serdes_link (
    input  logic                           clock,
    input  logic                           reset_n,
    input  logic                           prbs_en,
    input  logic                           load_start,
    input  serdes_pkg::coef_load_s         coef_load,
    output logic                           load_done,
    output logic [`SERDES_COUNT_WIDTH-1:0] bit_count,
    output logic [`SERDES_COUNT_WIDTH-1:0] error_count
);

    serdes_pkg::tap_write_s tap_write;      // control -> channel
    logic                   run_enable;     // control -> generator
    serdes_pkg::bits_s      tx_bits;        // generator -> transmitter
    serdes_pkg::sample_s    tx_sample;      // transmitter -> channel
    serdes_pkg::sample_s    rx_sample;      // channel -> receiver
    serdes_pkg::bits_s      rx_bits;        // receiver -> checker

    link_control u_link_control (
        .clock      (clock),
        .reset_n    (reset_n),
        .load_start (load_start),
        .coef_load  (coef_load),
        .prbs_en    (prbs_en),
        .tap_write  (tap_write),
        .run_enable (run_enable),
        .load_done  (load_done)
    );

    prbs31_gen u_prbs31_gen (
        .clock      (clock),
        .reset_n    (reset_n),
        .run_enable (run_enable),
        .bits_out   (tx_bits)
    );

    pam4_transmitter u_pam4_transmitter (
        .clock      (clock),
        .reset_n    (reset_n),
        .bits_in    (tx_bits),
        .sample_out (tx_sample)
    );

    isi_channel u_isi_channel (
        .clock      (clock),
        .reset_n    (reset_n),
        .tap_write  (tap_write),
        .sample_in  (tx_sample),
        .sample_out (rx_sample)
    );

    pam4_receiver u_pam4_receiver (
        .clock      (clock),
        .reset_n    (reset_n),
        .sample_in  (rx_sample),
        .bits_out   (rx_bits)
    );

    prbs31_checker u_prbs31_checker (
        .clock       (clock),
        .reset_n     (reset_n),
        .bits_in     (rx_bits),
        .bit_count   (bit_count),
        .error_count (error_count)
    );

endmodule

//--- receiver/pam4_receiver.sv
`timescale 1ns/1ps
`include "serdes_macros.svh"

module pam4_receiver (
    input  logic                clock,
    input  logic                reset_n,
    input  serdes_pkg::sample_s sample_in,
    output serdes_pkg::bits_s   bits_out
);

    // thresholds sit halfway between levels, -56 / 0 / +56
    localparam int THRESH = `SERDES_SYMBOL_SEPARATION;

    logic [1:0]        symbol;      // sliced level index
    serdes_pkg::pair_t pair;

    always_comb begin
        // ties go to the upper level
        if (sample_in.level >= THRESH)
            symbol = 2'd3;
        else if (sample_in.level >= 0)
            symbol = 2'd2;
        else if (sample_in.level >= -THRESH)
            symbol = 2'd1;
        else
            symbol = 2'd0;
    end

    // undo gray, 0->00 1->01 2->11 3->10
    assign pair = {symbol[1], symbol[1] ^ symbol[0]};

    always_ff @(posedge clock) begin
        if (!reset_n)
            bits_out.valid <= 1'b0;
        else
            bits_out.valid <= sample_in.valid;
        bits_out.pair <= pair;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the serdes_link testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module serdes_link_tb -Mdir obj_dir -f serdes_link.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vserdes_link_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
fi
exit $status

//--- serdes_link.f
+incdir+common
common/serdes_pkg.sv
logic/link_control.sv
logic/prbs31_gen.sv
transmitter/pam4_transmitter.sv
channel/isi_channel.sv
receiver/pam4_receiver.sv
checker/prbs31_checker.sv
logic/serdes_link.sv
testbench/serdes_link_tb.sv

//--- testbench/serdes_link_tb.sv
`timescale 1ns/1ps
`include "serdes_macros.svh"

module serdes_link_tb;

    localparam int W            = `SERDES_COUNT_WIDTH;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int LOAD_CYCLES  = 12;   // start, two words, wait for load_done
    localparam int GATE_CYCLES  = 40;
    localparam int RUN_CYCLES   = 200;
    localparam int PAUSE_ROUNDS = 12;
    localparam int MAX_PAUSE    = 12;   // 5 drain cycles plus up to 7 held
    localparam int MAX_BURST    = 24;
    localparam int TEST_CYCLES  = 3 * RESET_CYCLES + GATE_CYCLES + 3 * RUN_CYCLES
                                + PAUSE_ROUNDS * (MAX_PAUSE + MAX_BURST)
                                + 3 * LOAD_CYCLES + 20;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 200;

    logic                   clock;
    logic                   reset_n;
    logic                   prbs_en;
    logic                   load_start;
    serdes_pkg::coef_load_s coef_load;
    logic                   load_done;
    logic [W-1:0]           bit_count;
    logic [W-1:0]           error_count;

    // reference model state
    serdes_pkg::link_state_e m_state = serdes_pkg::LINK_IDLE;
    int           m_idx = 0;            // next tap to load
    int           m_taps [2];
    int           m_prev = 0;           // last transmitted voltage
    logic [30:0]  m_sr = `SERDES_PRBS_SEED;
    int           pend_bits [4];        // increments still inside the pipe
    int           pend_errs [4];
    logic [W-1:0] exp_bits = '0;
    logic [W-1:0] exp_errs = '0;
    integer       seed = 78;

    serdes_link uut (
        .clock       (clock),
        .reset_n     (reset_n),
        .prbs_en     (prbs_en),
        .load_start  (load_start),
        .coef_load   (coef_load),
        .load_done   (load_done),
        .bit_count   (bit_count),
        .error_count (error_count)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [W-1:0] expected,
                                   input logic [W-1:0] actual);
        fail_run($sformatf("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual));
    endtask

    function automatic logic [30:0] lfsr_step(input logic [30:0] s);
        return {s[29:0], s[30] ^ s[27]};    // x^31 + x^28 + 1
    endfunction

    // gray order 00 01 11 10 from lowest to highest voltage
    function automatic int pam4_voltage(input logic [1:0] pair);
        int idx;
        case (pair)
            2'b00:   idx = 0;
            2'b01:   idx = 1;
            2'b11:   idx = 2;
            default: idx = 3;
        endcase
        return idx * `SERDES_SYMBOL_SEPARATION - 3 * `SERDES_SYMBOL_SEPARATION / 2;
    endfunction

    function automatic int channel_out(input int cur, input int prev, input int t0, input int t1);
        int v;
        v = (cur * t0 + prev * t1) >>> `SERDES_COEF_SHIFT;     // floor division
        if (v > 127)
            v = 127;
        else if (v < -128)
            v = -128;
        return v;
    endfunction

    function automatic logic [1:0] slice_pair(input int v);
        if (v >= `SERDES_SYMBOL_SEPARATION)
            return 2'b10;
        else if (v >= 0)
            return 2'b11;
        else if (v >= -`SERDES_SYMBOL_SEPARATION)
            return 2'b01;
        return 2'b00;
    endfunction

    function automatic int pair_errors(input logic [1:0] a, input logic [1:0] b);
        return int'(a[1] ^ b[1]) + int'(a[0] ^ b[0]);
    endfunction

    always @(posedge clock) begin : ref_model
        logic       enabled;
        logic [1:0] sent;
        logic [1:0] recv;
        int         level;
        if (!reset_n) begin
            m_state  = serdes_pkg::LINK_IDLE;
            m_idx    = 0;
            m_taps[0] = 0;
            m_taps[1] = 0;
            m_prev   = 0;
            m_sr     = `SERDES_PRBS_SEED;
            exp_bits = '0;
            exp_errs = '0;
            for (int i = 0; i < 4; i++) begin
                pend_bits[i] = 0;
                pend_errs[i] = 0;
            end
        end else begin
            enabled  = (m_state == serdes_pkg::LINK_RUN) && prbs_en;
            // counters take what left the receiver this edge
            exp_bits = exp_bits + W'(pend_bits[3]);
            exp_errs = exp_errs + W'(pend_errs[3]);
            for (int i = 3; i > 0; i--) begin
                pend_bits[i] = pend_bits[i-1];
                pend_errs[i] = pend_errs[i-1];
            end
            pend_bits[0] = 0;
            pend_errs[0] = 0;
            if (enabled) begin
                m_sr    = lfsr_step(m_sr);
                sent[1] = m_sr[0];              // earlier bit is the msb
                m_sr    = lfsr_step(m_sr);
                sent[0] = m_sr[0];
                level   = pam4_voltage(sent);
                recv    = slice_pair(channel_out(level, m_prev, m_taps[0], m_taps[1]));
                m_prev  = level;
                pend_bits[0] = 2;
                pend_errs[0] = pair_errors(sent, recv);
            end
            case (m_state)
                serdes_pkg::LINK_IDLE: begin
                    if (load_start)
                        m_state = serdes_pkg::LINK_LOAD;
                end
                serdes_pkg::LINK_LOAD: begin
                    if (coef_load.valid) begin
                        m_taps[m_idx] = int'(coef_load.coef);   // sign extended
                        if (m_idx == 1)
                            m_state = serdes_pkg::LINK_RUN;
                        m_idx++;
                    end
                end
                default: ;                      // run is sticky, load words dropped
            endcase
        end
    end

    // negedge sampling, both model and dut settled by then
    check_bit_count: assert property (@(negedge clock) disable iff (!reset_n)
        bit_count == exp_bits)
        else report_mismatch("bit_count", exp_bits, bit_count);

    check_error_count: assert property (@(negedge clock) disable iff (!reset_n)
        error_count == exp_errs)
        else report_mismatch("error_count", exp_errs, error_count);

    check_load_done: assert property (@(negedge clock) disable iff (!reset_n)
        load_done == (m_state == serdes_pkg::LINK_RUN))
        else report_mismatch("load_done", W'(m_state == serdes_pkg::LINK_RUN), W'(load_done));

    task automatic step();
        @(posedge clock);
        #2;
    endtask

    task automatic apply_reset();
        reset_n    = 1'b0;
        prbs_en    = 1'b0;
        load_start = 1'b0;
        coef_load  = '0;
        repeat (RESET_CYCLES) step();
        reset_n    = 1'b1;
    endtask

    task automatic load_taps(input int cursor, input int post);
        int waited;
        load_start      = 1'b1;
        step();
        load_start      = 1'b0;
        coef_load.valid = 1'b1;
        coef_load.coef  = serdes_pkg::coef_t'(cursor);
        step();
        coef_load.coef  = serdes_pkg::coef_t'(post);
        step();
        coef_load = '0;
        waited    = 0;
        while (!load_done && waited < LOAD_CYCLES) begin
            step();
            waited++;
        end
        assert (load_done) else fail_run("load_done never rose after both taps were sent");
    endtask

    task automatic run_cycles(input int n);
        prbs_en = 1'b1;
        repeat (n) step();
    endtask

    // hold prbs_en low, counters must sit still once the pipe drains
    task automatic pause_link();
        int           extra;
        logic [W-1:0] held_bits;
        logic [W-1:0] held_errs;
        extra   = 1 + {$random(seed)} % (MAX_PAUSE - 5);
        prbs_en = 1'b0;
        repeat (5) step();
        held_bits = bit_count;
        held_errs = error_count;
        repeat (extra) step();
        assert (bit_count == held_bits) else report_mismatch("bit_count", held_bits, bit_count);
        assert (error_count == held_errs)
            else report_mismatch("error_count", held_errs, error_count);
    endtask

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        fail_run("the run took longer than the watchdog limit");
    end

    initial begin : stimulus
        int burst;
        reset_n    = 1'b0;
        prbs_en    = 1'b0;
        load_start = 1'b0;
        coef_load  = '0;
        repeat (RESET_CYCLES) step();
        reset_n = 1'b1;

        run_cycles(GATE_CYCLES);            // gate still shut, no taps yet
        assert (!load_done && bit_count == 0)
            else fail_run("pattern flowed before any taps were loaded");

        load_taps(64, 0);                   // clean channel
        run_cycles(RUN_CYCLES);
        prbs_en = 1'b0;
        repeat (5) step();
        assert (bit_count == W'(2 * RUN_CYCLES))
            else report_mismatch("bit_count", W'(2 * RUN_CYCLES), bit_count);

        for (int r = 0; r < PAUSE_ROUNDS; r++) begin
            pause_link();
            burst = 1 + {$random(seed)} % MAX_BURST;
            run_cycles(burst);
        end

        // load attempt while running, tap values that would break the link
        load_start      = 1'b1;
        coef_load.valid = 1'b1;
        coef_load.coef  = 8'sd127;
        step();
        load_start = 1'b0;
        step();
        coef_load = '0;
        run_cycles(MAX_BURST);
        assert (error_count == 0) else report_mismatch("error_count", '0, error_count);

        apply_reset();
        load_taps(64, 8);                   // isi of 10 at most, margin 28
        run_cycles(RUN_CYCLES);
        assert (error_count == 0) else report_mismatch("error_count", '0, error_count);

        apply_reset();
        load_taps(64, 48);                  // post-cursor pushes inner levels across
        run_cycles(RUN_CYCLES);
        prbs_en = 1'b0;
        repeat (6) step();
        assert (error_count != 0) else fail_run("heavy interference produced no bit errors");

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- transmitter/pam4_transmitter.sv
`timescale 1ns/1ps
`include "serdes_macros.svh"

module pam4_transmitter (
    input  logic                clock,
    input  logic                reset_n,
    input  serdes_pkg::bits_s   bits_in,
    output serdes_pkg::sample_s sample_out
);

    localparam int OUTER = 3 * `SERDES_SYMBOL_SEPARATION / 2;   // 84
    localparam int INNER = `SERDES_SYMBOL_SEPARATION / 2;       // 28

    logic [1:0]         symbol;     // level index 0..3
    serdes_pkg::level_t voltage;

    // gray: 00->0, 01->1, 11->2, 10->3
    assign symbol = {bits_in.pair[1], bits_in.pair[1] ^ bits_in.pair[0]};

    always_comb begin
        case (symbol)
            2'd0:    voltage = serdes_pkg::level_t'(-OUTER);
            2'd1:    voltage = serdes_pkg::level_t'(-INNER);
            2'd2:    voltage = serdes_pkg::level_t'(INNER);
            default: voltage = serdes_pkg::level_t'(OUTER);
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n)
            sample_out.valid <= 1'b0;
        else
            sample_out.valid <= bits_in.valid;
        sample_out.level <= voltage;    // no reset on the data path
    end

endmodule
